/* glm_seq.f */
verilog/glm_isa_pkg.sv
verilog/glm_host_pkg.sv
verilog/glm_csr_regs.sv
verilog/glm_program_loader.sv
verilog/glm_program_ram.sv
verilog/glm_sequencer.sv
verilog/glm_top.sv
verification/glm_top_chk.sv
verification/glm_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sequencer testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f glm_seq.f \
    --top-module glm_top_tb -o glm_top_sim > build.log 2>&1 \
    && ./obj_dir/glm_top_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

/* verification/glm_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_top_tb;

    localparam int NUM_ROWS = 3;
    localparam int TIMEOUT_CYCLES = 5000;

    logic clk;
    logic reset;
    glm_host_pkg::csr_write_t csr_wr;
    glm_host_pkg::rd_rsp_t rd_rsp;
    logic rd_almost_full;
    logic wr_almost_full;
    glm_isa_pkg::op_mask_t op_done;
    glm_host_pkg::rd_req_t rd_req;
    glm_host_pkg::wr_req_t wr_req;
    glm_isa_pkg::op_mask_t op_start;
    glm_isa_pkg::op_args_t op_args;

    // ========================================
    // program table, one row per run
    // ========================================

    glm_isa_pkg::line_t prog_lines [16];
    glm_host_pkg::cl_addr_t row_base [NUM_ROWS];
    glm_host_pkg::cl_addr_t row_out [NUM_ROWS];
    int row_first [NUM_ROWS];
    int row_len [NUM_ROWS];
    int row_count [NUM_ROWS][glm_isa_pkg::NUM_OP_CLASSES];

    // expected dispatch sequence from the reference model
    glm_isa_pkg::op_mask_t exp_mask [$];
    glm_isa_pkg::op_args_t exp_args [$];
    logic exp_nb [$];

    glm_isa_pkg::line_t rsp_data [$];
    int rsp_due [$];

    glm_host_pkg::cl_addr_t cur_base;
    glm_host_pkg::cl_addr_t cur_out;
    int cur_first;
    int cur_len;
    int rd_count;
    int write_count;
    int seen_count [glm_isa_pkg::NUM_OP_CLASSES];
    int cycle;
    int last_due;
    int done_due;
    logic busy;
    glm_isa_pkg::op_mask_t busy_mask;
    logic [31:0] rnd;

    glm_top glm_top_i
    (
        .clk,
        .reset,
        .csr_wr,
        .rd_rsp,
        .rd_almost_full,
        .wr_almost_full,
        .op_done,
        .rd_req,
        .wr_req,
        .op_start,
        .op_args
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic glm_isa_pkg::line_t make_instr(
        input logic [31:0] c0, input logic [31:0] c1, input logic [31:0] c2,
        input logic [31:0] arg_base, input logic [31:0] s0, input logic [31:0] s1,
        input logic [31:0] s2, input logic [31:0] cmp, input logic [31:0] tgt,
        input logic [31:0] ctrl
    );
        glm_isa_pkg::line_t l;
        l = '0;
        l[0 +: 32] = c0;
        l[32 +: 32] = c1;
        l[64 +: 32] = c2;
        for (int i = 0; i < 4; i++)
        begin
            l[(3 + i) * 32 +: 32] = arg_base + 32'(i);
        end
        l[10 * 32 +: 32] = s0;
        l[11 * 32 +: 32] = s1;
        l[12 * 32 +: 32] = s2;
        l[13 * 32 +: 32] = cmp;
        l[14 * 32 +: 32] = tgt;
        l[15 * 32 +: 32] = ctrl;
        return l;
    endfunction

    task automatic load_table();
        logic [31:0] h;
        logic [31:0] inc;
        logic [31:0] dec;
        h = glm_isa_pkg::IDX_HOLD;
        inc = glm_isa_pkg::IDX_INC;
        dec = glm_isa_pkg::IDX_DEC;
        // loop on index 0, then a nonblocking class 4, then halt
        prog_lines[0] = make_instr(inc, h, h, 32'hA0, 3, 5, 7, 3, 32'h0000_0001, 32'h011);
        prog_lines[1] = make_instr(h, h, h, 32'hB0, 0, 0, 0, 0, 0, 32'h140);
        prog_lines[2] = make_instr(h, h, h, 0, 0, 0, 0, 0, 32'hFFFF_FFFF, 32'h001);
        // loads, decrement loop on index 1, then jumps on index 0 and 2
        prog_lines[3] = make_instr(h, 2, 5, 0, 0, 0, 0, 0, 0, 32'h000);
        prog_lines[4] = make_instr(inc, dec, h, 32'hC0, 4, 6, 8, 0, 32'h0001_0003, 32'h022);
        prog_lines[5] = make_instr(h, h, h, 32'hD0, 0, 0, 0, 5, 32'h0000_0004, 32'h153);
        prog_lines[6] = make_instr(h, h, h, 32'hE0, 0, 0, 0, 3, 32'hFFFF_0002, 32'h061);
        prog_lines[7] = make_instr(h, h, h, 32'hF0, 2, 2, 2, 0, 32'hFFFF_FFFF, 32'h031);
        row_base = '{42'h100, 42'h3_0005, 42'h1234};
        row_out = '{42'h200, 42'h400, 42'h10};
        row_first = '{0, 3, 0};
        row_len = '{3, 5, 3};
        row_count = '{'{4, 0, 0, 1, 0, 0}, '{0, 3, 1, 0, 1, 1}, '{4, 0, 0, 1, 0, 0}};
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // ========================================
    // compare tasks
    // ========================================

    task automatic check_rd_req(input glm_host_pkg::cl_addr_t got,
                                input glm_host_pkg::cl_addr_t exp);
        if (got !== exp)
        begin
            stop_run($sformatf("Mismatch rd_req.addr: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_dispatch(input glm_isa_pkg::op_mask_t got_m,
                                  input glm_isa_pkg::op_args_t got_a,
                                  input glm_isa_pkg::op_mask_t exp_m,
                                  input glm_isa_pkg::op_args_t exp_a);
        if (got_m !== exp_m)
        begin
            stop_run($sformatf("Mismatch op_start: got %h expected %h", got_m, exp_m));
        end
        if (got_a !== exp_a)
        begin
            stop_run($sformatf("Mismatch op_args: got %h expected %h", got_a, exp_a));
        end
    endtask

    task automatic check_write(input glm_host_pkg::wr_req_t got,
                               input glm_host_pkg::wr_req_t exp);
        if (got !== exp)
        begin
            stop_run($sformatf("Mismatch wr_req: got %h expected %h", got, exp));
        end
    endtask

    // ========================================
    // reference model of the instruction set
    // ========================================

    function automatic logic [31:0] update_index(input logic [31:0] code,
                                                 input logic [31:0] cur);
        if (code == 32'hFFFF_FFFF)
            return cur;
        else if (code == 32'h0FFF_FFFF)
            return cur + 1;
        else if (code == 32'h01FF_FFFF)
            return cur - 1;
        return code;
    endfunction

    task automatic build_model(input int r);
        logic [31:0] regs [3];
        logic [31:0] w [16];
        glm_isa_pkg::op_args_t a;
        glm_isa_pkg::op_mask_t m;
        int counts [glm_isa_pkg::NUM_OP_CLASSES];
        int pc;
        int sel;
        int cls;
        int steps;
        regs = '{0, 0, 0};
        counts = '{default: 0};
        pc = 0;
        steps = 0;
        while (pc != 16'hFFFF)
        begin
            if (pc >= row_len[r] || steps > 200)
            begin
                stop_run("reference model left the program or did not halt");
            end
            for (int i = 0; i < 16; i++)
            begin
                w[i] = prog_lines[row_first[r] + pc][i * 32 +: 32];
            end
            sel = int'(w[15][3:0]);
            cls = int'(w[15][7:4]);
            if (cls >= 1 && cls <= 6)
            begin
                m = '0;
                m[cls - 1] = 1'b1;
                for (int i = 0; i < 3; i++)
                begin
                    a.idx[i] = (cls <= 3) ? regs[i] * w[10 + i] : regs[i];
                end
                for (int i = 0; i < 4; i++)
                begin
                    a.arg[i] = w[3 + i];
                end
                exp_mask.push_back(m);
                exp_args.push_back(a);
                exp_nb.push_back(w[15][8]);
                counts[cls - 1]++;
            end
            if (sel >= 1 && sel <= 3)
                pc = (regs[sel - 1] == w[13]) ? int'(w[14][15:0]) : int'(w[14][31:16]);
            else
                pc = pc + 1;
            for (int i = 0; i < 3; i++)
            begin
                regs[i] = update_index(w[i], regs[i]);
            end
            steps++;
        end
        if (counts != row_count[r])
        begin
            stop_run("reference model dispatch counts differ from the table");
        end
    endtask

    // ========================================
    // host memory and engine model
    // ========================================

    always @(posedge clk)
    begin
        glm_host_pkg::wr_req_t exp_wr;
        cycle++;
        rnd = lcg_next(rnd);
        rd_almost_full <= (rnd[31:30] == 2'b00);
        wr_almost_full <= rnd[29];
        rd_rsp <= '0;
        op_done <= '0;
        if (!reset)
        begin
            if (rd_req.valid)
            begin
                if (rd_count >= cur_len)
                    stop_run("read request beyond the program length");
                check_rd_req(rd_req.addr, cur_base + glm_host_pkg::cl_addr_t'(rd_count));
                rsp_data.push_back(prog_lines[cur_first + rd_count]);
                last_due = (cycle + 1 + int'(rnd[28:27]) > last_due + 1)
                    ? cycle + 1 + int'(rnd[28:27]) : last_due + 1;
                rsp_due.push_back(last_due);
                rd_count++;
            end
            if (rsp_due.size() > 0 && rsp_due[0] <= cycle)
            begin
                rd_rsp.valid <= 1'b1;
                rd_rsp.data <= rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end
            if (op_start != '0)
            begin
                if (busy)
                    stop_run("dispatch while a blocking operation was still running");
                if (exp_mask.size() == 0)
                    stop_run("dispatch not predicted by the reference model");
                check_dispatch(op_start, op_args, exp_mask[0], exp_args[0]);
                for (int c = 0; c < glm_isa_pkg::NUM_OP_CLASSES; c++)
                begin
                    if (op_start[c])
                        seen_count[c]++;
                end
                if (!exp_nb[0])
                begin
                    busy = 1'b1;
                    busy_mask = op_start;
                    done_due = cycle + 1 + int'(rnd[26:25]);
                end
                void'(exp_mask.pop_front());
                void'(exp_args.pop_front());
                void'(exp_nb.pop_front());
            end
            if (busy && cycle >= done_due)
            begin
                op_done <= busy_mask;
                busy = 1'b0;
            end
            if (wr_req.valid)
            begin
                exp_wr.valid = 1'b1;
                exp_wr.addr = cur_out;
                exp_wr.data = glm_isa_pkg::line_t'(1);
                if (exp_mask.size() != 0 || write_count != 0)
                    stop_run("completion write too early or repeated");
                check_write(wr_req, exp_wr);
                write_count++;
            end
        end
    end

    task automatic write_csr(input logic [1:0] index, input logic [63:0] data);
        @(posedge clk);
        csr_wr.valid <= 1'b1;
        csr_wr.index <= index;
        csr_wr.data <= data;
    endtask

    task automatic run_row(input int r);
        int n;
        cur_base = row_base[r];
        cur_out = row_out[r];
        cur_first = row_first[r];
        cur_len = row_len[r];
        rd_count = 0;
        write_count = 0;
        seen_count = '{default: 0};
        build_model(r);
        write_csr(glm_host_pkg::CSR_PROGRAM_ADDR, 64'({cur_base, 6'b0}));
        write_csr(glm_host_pkg::CSR_OUT_ADDR, 64'({cur_out, 6'b0}));
        write_csr(glm_host_pkg::CSR_START, 64'(cur_len));
        @(posedge clk);
        csr_wr <= '0;
        for (n = 0; n < TIMEOUT_CYCLES && write_count == 0; n++)
            @(posedge clk);
        if (write_count == 0)
            stop_run("timeout waiting for the completion write");
        // quiet period to catch a second write
        for (n = 0; n < 20; n++)
            @(posedge clk);
        if (rd_count != cur_len || seen_count != row_count[r])
            stop_run("read or dispatch count differs at the end of the run");
    endtask

    initial
    begin
        reset = 1'b1;
        csr_wr = '0;
        rd_rsp = '0;
        rd_almost_full = 1'b0;
        wr_almost_full = 1'b0;
        op_done = '0;
        rnd = 32'h1157_e6b2;
        cycle = 0;
        last_due = 0;
        busy = 1'b0;
        load_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/glm_top_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_top_chk
(
    input wire logic clk,
    input wire logic reset,
    input wire glm_host_pkg::rd_req_t rd_req,
    input wire glm_host_pkg::wr_req_t wr_req,
    input wire glm_isa_pkg::op_mask_t op_start,
    input wire logic rd_almost_full,
    input wire logic wr_almost_full
);

    // at most one operation class starts at a time
    onehot_start: assert property (@(posedge clk) disable iff (reset) $onehot0(op_start))
        else $error("op_start has more than one class set");

    // level sampled one cycle earlier gates the request
    read_backpressure: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> !$past(rd_almost_full))
        else $error("read request after rd_almost_full");

    write_backpressure: assert property (@(posedge clk) disable iff (reset)
        wr_req.valid |-> !wr_almost_full)
        else $error("write request while wr_almost_full");

    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!rd_req.valid && !wr_req.valid && op_start == '0))
        else $error("output active during reset");

endmodule

bind glm_top glm_top_chk chk_i (.*);

`default_nettype wire

/* verilog/glm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_top
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire glm_host_pkg::csr_write_t csr_wr,
    input  wire glm_host_pkg::rd_rsp_t rd_rsp,
    input  wire logic rd_almost_full,
    input  wire logic wr_almost_full,
    input  wire glm_isa_pkg::op_mask_t op_done,
    output glm_host_pkg::rd_req_t rd_req,
    output glm_host_pkg::wr_req_t wr_req,
    output glm_isa_pkg::op_mask_t op_start,
    output glm_isa_pkg::op_args_t op_args
);

    glm_host_pkg::cl_addr_t out_addr;
    glm_host_pkg::cl_addr_t program_addr;
    glm_host_pkg::prog_len_t program_length;
    logic start;

    logic ram_we;
    glm_host_pkg::prog_addr_t ram_waddr;
    glm_isa_pkg::line_t ram_wdata;
    logic ram_re;
    glm_host_pkg::prog_addr_t ram_raddr;
    glm_isa_pkg::line_t ram_rdata;
    logic ram_rvalid;

    logic program_ready;
    logic halted;

    // ========================================
    // host registers and program fetch
    // ========================================

    glm_csr_regs csr_regs_i
    (
        .clk,
        .reset,
        .csr_wr,
        .out_addr,
        .program_addr,
        .program_length,
        .start
    );

    glm_program_loader program_loader_i
    (
        .clk,
        .reset,
        .start,
        .program_addr,
        .program_length,
        .out_addr,
        .rd_req,
        .rd_rsp,
        .rd_almost_full,
        .wr_req,
        .wr_almost_full,
        .ram_we,
        .ram_waddr,
        .ram_wdata,
        .halted,
        .program_ready
    );

    // ========================================
    // program memory and register machine
    // ========================================

    glm_program_ram program_ram_i
    (
        .clk,
        .we(ram_we),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .re(ram_re),
        .raddr(ram_raddr),
        .rdata(ram_rdata),
        .rvalid(ram_rvalid)
    );

    glm_sequencer sequencer_i
    (
        .clk,
        .reset,
        .program_ready,
        .ram_re,
        .ram_raddr,
        .ram_rdata,
        .ram_rvalid,
        .op_start,
        .op_args,
        .op_done,
        .halted
    );

endmodule

`default_nettype wire

/* verilog/glm_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_sequencer
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic program_ready,
    output logic ram_re,
    output glm_host_pkg::prog_addr_t ram_raddr,
    input  wire glm_isa_pkg::line_t ram_rdata,
    input  wire logic ram_rvalid,
    output glm_isa_pkg::op_mask_t op_start,
    output glm_isa_pkg::op_args_t op_args,
    input  wire glm_isa_pkg::op_mask_t op_done,
    output logic halted
);

    function automatic glm_isa_pkg::instr_word_t word_of(glm_isa_pkg::line_t line, int pos);
        return line[pos*$bits(glm_isa_pkg::instr_word_t) +: $bits(glm_isa_pkg::instr_word_t)];
    endfunction

    // hold, increment, decrement, or load the code itself
    function automatic glm_isa_pkg::index_t next_index(
        glm_isa_pkg::instr_word_t code,
        glm_isa_pkg::index_t cur
    );
        glm_isa_pkg::index_t result;
        case (code)
            glm_isa_pkg::IDX_HOLD: result = cur;
            glm_isa_pkg::IDX_INC: result = cur + 1'b1;
            glm_isa_pkg::IDX_DEC: result = cur - 1'b1;
            default: result = code;
        endcase
        return result;
    endfunction

    glm_isa_pkg::seq_state_e state;
    glm_isa_pkg::pc_t pc;
    glm_isa_pkg::line_t instr;
    glm_isa_pkg::index_t regs [glm_isa_pkg::NUM_INDEX];
    glm_isa_pkg::index_t snap [glm_isa_pkg::NUM_INDEX];
    glm_isa_pkg::op_mask_t op_mask_q;
    logic nonblocking_q;

    glm_isa_pkg::instr_word_t ctrl_word;
    glm_isa_pkg::instr_word_t targets;
    logic [3:0] dec_sel;
    logic [3:0] dec_class;
    glm_isa_pkg::op_mask_t dec_mask;
    logic dec_strided;
    glm_isa_pkg::pc_t next_pc;
    logic may_continue;

    // ========================================
    // decode of the latched instruction
    // ========================================

    always_comb
    begin
        ctrl_word = word_of(instr, glm_isa_pkg::WORD_CONTROL);
        targets = word_of(instr, glm_isa_pkg::WORD_TARGETS);
        dec_sel = ctrl_word[3:0];
        dec_class = ctrl_word[7:4];
        for (int i = 0; i < glm_isa_pkg::NUM_OP_CLASSES; i++)
        begin
            dec_mask[i] = (dec_class == 4'(i + 1));
        end
        dec_strided = (dec_class != 4'd0) && (dec_class <= glm_isa_pkg::NUM_STRIDED_CLASSES);

        // selects 1 to 3 compare one index with word 13
        if (dec_sel != 4'd0 && dec_sel <= glm_isa_pkg::NUM_INDEX)
        begin
            if (snap[dec_sel[1:0] - 2'd1] == word_of(instr, glm_isa_pkg::WORD_COMPARE))
            begin
                next_pc = targets[15:0];
            end
            else
            begin
                next_pc = targets[31:16];
            end
        end
        else
        begin
            next_pc = pc + 1'b1;
        end
    end

    // class 0 and nonblocking ops do not wait for the engine
    assign may_continue = (op_mask_q == '0) || nonblocking_q || |(op_done & op_mask_q);
    assign halted = (state == glm_isa_pkg::DONE);

    // ========================================
    // register machine
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= glm_isa_pkg::IDLE;
            pc <= '0;
            ram_re <= 1'b0;
            op_start <= '0;
            op_mask_q <= '0;
            nonblocking_q <= 1'b0;
        end
        else
        begin
            ram_re <= 1'b0;
            op_start <= '0;
            case (state)
                glm_isa_pkg::IDLE:
                begin
                    for (int i = 0; i < glm_isa_pkg::NUM_INDEX; i++)
                    begin
                        regs[i] <= '0;
                    end
                    if (program_ready)
                    begin
                        ram_re <= 1'b1;
                        ram_raddr <= glm_host_pkg::prog_addr_t'(pc);
                        state <= glm_isa_pkg::RECEIVE;
                    end
                end

                glm_isa_pkg::RECEIVE:
                begin
                    if (ram_rvalid)
                    begin
                        instr <= ram_rdata;
                        snap <= regs;
                        state <= glm_isa_pkg::DECODE;
                    end
                end

                glm_isa_pkg::DECODE:
                begin
                    op_mask_q <= dec_mask;
                    nonblocking_q <= ctrl_word[glm_isa_pkg::NONBLOCK_BIT];
                    op_start <= dec_mask;
                    // operands only change on a real dispatch
                    if (dec_mask != '0)
                    begin
                        for (int i = 0; i < glm_isa_pkg::NUM_INDEX; i++)
                        begin
                            if (dec_strided)
                            begin
                                op_args.idx[i] <= snap[i]
                                    * word_of(instr, glm_isa_pkg::WORD_STRIDE_FIRST + i);
                            end
                            else
                            begin
                                op_args.idx[i] <= snap[i];
                            end
                        end
                        for (int i = 0; i < glm_isa_pkg::NUM_ARGS; i++)
                        begin
                            op_args.arg[i] <= word_of(instr, glm_isa_pkg::WORD_ARG_FIRST + i);
                        end
                    end
                    pc <= next_pc;
                    state <= glm_isa_pkg::EXECUTE;
                end

                glm_isa_pkg::EXECUTE:
                begin
                    if (pc == glm_isa_pkg::PC_HALT)
                    begin
                        state <= glm_isa_pkg::DONE;
                    end
                    else if (may_continue)
                    begin
                        ram_re <= 1'b1;
                        ram_raddr <= glm_host_pkg::prog_addr_t'(pc);
                        // words 0 to 2 carry the index update codes
                        for (int i = 0; i < glm_isa_pkg::NUM_INDEX; i++)
                        begin
                            regs[i] <= next_index(word_of(instr, i), regs[i]);
                        end
                        state <= glm_isa_pkg::RECEIVE;
                    end
                end

                glm_isa_pkg::DONE:
                begin
                    pc <= '0;
                    state <= glm_isa_pkg::IDLE;
                end

                default:
                begin
                    state <= glm_isa_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/glm_program_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_program_ram
(
    input  wire logic clk,
    input  wire logic we,
    input  wire glm_host_pkg::prog_addr_t waddr,
    input  wire glm_isa_pkg::line_t wdata,
    input  wire logic re,
    input  wire glm_host_pkg::prog_addr_t raddr,
    output glm_isa_pkg::line_t rdata,
    output logic rvalid
);

    // one instruction per line
    glm_isa_pkg::line_t mem [2**glm_host_pkg::LOG2_PROGRAM_SIZE];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end

        if (re)
        begin
            rdata <= mem[raddr];
        end

        // valid tracks the enable with the same latency as the data
        rvalid <= re;
    end

endmodule

`default_nettype wire

/* verilog/glm_program_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_program_loader
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  wire glm_host_pkg::cl_addr_t program_addr,
    input  wire glm_host_pkg::prog_len_t program_length,
    input  wire glm_host_pkg::cl_addr_t out_addr,
    output glm_host_pkg::rd_req_t rd_req,
    input  wire glm_host_pkg::rd_rsp_t rd_rsp,
    input  wire logic rd_almost_full,
    output glm_host_pkg::wr_req_t wr_req,
    input  wire logic wr_almost_full,
    output logic ram_we,
    output glm_host_pkg::prog_addr_t ram_waddr,
    output glm_isa_pkg::line_t ram_wdata,
    input  wire logic halted,
    output logic program_ready
);

    glm_host_pkg::dma_state_e req_state;
    glm_host_pkg::dma_state_e rcv_state;
    glm_host_pkg::prog_len_t req_count;
    glm_host_pkg::prog_len_t rcv_count;
    glm_host_pkg::prog_len_t last_line;

    assign last_line = program_length - glm_host_pkg::prog_len_t'(1);

    // ========================================
    // request side
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_state <= glm_host_pkg::IDLE;
            req_count <= '0;
            rd_req.valid <= 1'b0;
        end
        else
        begin
            rd_req.valid <= 1'b0;
            case (req_state)
                glm_host_pkg::IDLE:
                begin
                    if (start)
                    begin
                        req_count <= '0;
                        req_state <= glm_host_pkg::PROGRAM_READ;
                    end
                end

                glm_host_pkg::PROGRAM_READ:
                begin
                    // one line per cycle, held off by the sampled level
                    if (req_count < program_length && !rd_almost_full)
                    begin
                        rd_req.valid <= 1'b1;
                        rd_req.addr <= program_addr + glm_host_pkg::cl_addr_t'(req_count);
                        req_count <= req_count + 1'b1;
                        if (req_count == last_line)
                        begin
                            req_state <= glm_host_pkg::EXECUTE;
                        end
                    end
                end

                glm_host_pkg::EXECUTE:
                begin
                    if (halted)
                    begin
                        req_state <= glm_host_pkg::DONE;
                    end
                end

                glm_host_pkg::DONE:
                begin
                    req_state <= glm_host_pkg::IDLE;
                end
            endcase
        end
    end

    // ========================================
    // receive side and completion write
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rcv_state <= glm_host_pkg::IDLE;
            rcv_count <= '0;
            ram_we <= 1'b0;
        end
        else
        begin
            ram_we <= 1'b0;
            case (rcv_state)
                glm_host_pkg::IDLE:
                begin
                    if (start)
                    begin
                        rcv_count <= '0;
                        rcv_state <= glm_host_pkg::PROGRAM_READ;
                    end
                end

                glm_host_pkg::PROGRAM_READ:
                begin
                    // responses come back in order, so a counter is the address
                    if (rd_rsp.valid)
                    begin
                        ram_we <= 1'b1;
                        ram_waddr <= glm_host_pkg::prog_addr_t'(rcv_count);
                        ram_wdata <= rd_rsp.data;
                        rcv_count <= rcv_count + 1'b1;
                        if (rcv_count == last_line)
                        begin
                            rcv_state <= glm_host_pkg::EXECUTE;
                        end
                    end
                end

                glm_host_pkg::EXECUTE:
                begin
                    if (halted)
                    begin
                        rcv_state <= glm_host_pkg::DONE;
                    end
                end

                glm_host_pkg::DONE:
                begin
                    if (!wr_almost_full)
                    begin
                        rcv_state <= glm_host_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    assign program_ready = (rcv_state == glm_host_pkg::EXECUTE);

    // completion flag, value 1 at the output line
    always_comb
    begin
        wr_req.valid = (rcv_state == glm_host_pkg::DONE) && !wr_almost_full;
        wr_req.addr = out_addr;
        wr_req.data = glm_isa_pkg::line_t'(1);
    end

endmodule

`default_nettype wire

/* verilog/glm_csr_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module glm_csr_regs
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire glm_host_pkg::csr_write_t csr_wr,
    output glm_host_pkg::cl_addr_t out_addr,
    output glm_host_pkg::cl_addr_t program_addr,
    output glm_host_pkg::prog_len_t program_length,
    output logic start
);

    // drop the byte offset inside a line
    function automatic glm_host_pkg::cl_addr_t to_line_addr(glm_host_pkg::byte_addr_t addr);
        return addr[glm_host_pkg::CL_BYTE_IDX_BITS +: $bits(glm_host_pkg::cl_addr_t)];
    endfunction

    glm_host_pkg::byte_addr_t wr_byte_addr;

    assign wr_byte_addr = csr_wr.data[$bits(glm_host_pkg::byte_addr_t)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_addr <= '0;
            program_addr <= '0;
            program_length <= '0;
            start <= 1'b0;
        end
        else
        begin
            // start follows the length write by one cycle
            start <= csr_wr.valid && (csr_wr.index == glm_host_pkg::CSR_START);

            if (csr_wr.valid)
            begin
                case (csr_wr.index)
                    glm_host_pkg::CSR_OUT_ADDR:
                    begin
                        out_addr <= to_line_addr(wr_byte_addr);
                    end

                    glm_host_pkg::CSR_PROGRAM_ADDR:
                    begin
                        program_addr <= to_line_addr(wr_byte_addr);
                    end

                    glm_host_pkg::CSR_START:
                    begin
                        program_length <= csr_wr.data[$bits(glm_host_pkg::prog_len_t)-1:0];
                    end

                    default:
                    begin
                        // index 0 has no register here
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/glm_host_pkg.sv */
`default_nettype none

package glm_host_pkg;

    // ========================================
    // host addressing
    // ========================================

    localparam int CL_BYTE_IDX_BITS = 6;

    typedef logic [41:0] cl_addr_t;
    typedef logic [47:0] byte_addr_t;
    typedef logic [15:0] prog_len_t;

    localparam int LOG2_PROGRAM_SIZE = 6;
    typedef logic [LOG2_PROGRAM_SIZE-1:0] prog_addr_t;

    // register indices written by the host
    localparam logic [1:0] CSR_OUT_ADDR = 2'd1;
    localparam logic [1:0] CSR_PROGRAM_ADDR = 2'd2;
    localparam logic [1:0] CSR_START = 2'd3;

    typedef struct packed {
        logic valid;
        logic [1:0] index;
        logic [63:0] data;
    } csr_write_t;

    // ========================================
    // memory channels
    // ========================================

    typedef struct packed {
        logic valid;
        cl_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic valid;
        glm_isa_pkg::line_t data;
    } rd_rsp_t;

    typedef struct packed {
        logic valid;
        cl_addr_t addr;
        glm_isa_pkg::line_t data;
    } wr_req_t;

    typedef enum logic [1:0] {
        IDLE,
        PROGRAM_READ,
        EXECUTE,
        DONE
    } dma_state_e;

endpackage

`default_nettype wire

/* verilog/glm_isa_pkg.sv */
`default_nettype none

package glm_isa_pkg;

    // ========================================
    // instruction format
    // ========================================

    typedef logic [31:0] instr_word_t;
    typedef logic [511:0] line_t;
    typedef logic [15:0] pc_t;
    typedef logic [31:0] index_t;

    localparam int NUM_INDEX = 3;
    localparam int NUM_OP_CLASSES = 6;
    localparam int NUM_ARGS = 4;

    typedef logic [NUM_OP_CLASSES-1:0] op_mask_t;

    // word positions inside one 512-bit instruction line
    localparam int WORD_ARG_FIRST = 3;
    localparam int WORD_STRIDE_FIRST = 10;
    localparam int WORD_COMPARE = 13;
    localparam int WORD_TARGETS = 14;
    localparam int WORD_CONTROL = 15;

    // control word: [3:0] branch select, [7:4] class, [8] nonblocking
    localparam int NONBLOCK_BIT = 8;

    // index update codes, anything else is a load
    localparam index_t IDX_HOLD = 32'hFFFF_FFFF;
    localparam index_t IDX_INC = 32'h0FFF_FFFF;
    localparam index_t IDX_DEC = 32'h01FF_FFFF;

    localparam pc_t PC_HALT = 16'hFFFF;

    // classes 1 to 3 get index times stride
    localparam int NUM_STRIDED_CLASSES = 3;

    typedef struct packed {
        index_t [NUM_INDEX-1:0] idx;
        instr_word_t [NUM_ARGS-1:0] arg;
    } op_args_t;

    typedef enum logic [2:0] {
        IDLE,
        RECEIVE,
        DECODE,
        EXECUTE,
        DONE
    } seq_state_e;

endpackage

`default_nettype wire
